// ==== src.f ====
verilog/debug_pkg.sv
verilog/prog_if.sv
verilog/debug_fsm.sv
verilog/cycle_counter.sv
verilog/instr_loader.sv
verilog/dump_serializer.sv
verilog/debug_unit.sv
verification/tb_debug_unit.sv

// ==== verification/tb_debug_unit.sv ====
`default_nettype none

module tb_debug_unit;

    // Bytes received and sent over the whole run, and worst cycles per byte
    localparam int rx_byte_count = 36;
    localparam int tx_byte_count = 5 * debug_pkg::snapshot_bytes;
    localparam int timeout_cycles = 16 + rx_byte_count * 5 + tx_byte_count * 10 + 400;
    localparam logic [31:0] halt_instr = {debug_pkg::halt_opcode, 26'h0};

    logic        clk = 1'b0;
    logic        reset = 1'b1;
    logic [7:0]  rx_data = '0;
    logic        rx_done = 1'b0;
    logic        tx_done = 1'b0;
    logic        tx_start, imem_we, imem_erase, cpu_reset, cpu_run;
    logic [7:0]  tx_data;
    logic [5:0]  imem_addr;
    logic [31:0] imem_wdata, cpu_instr, cpu_pc, cpu_mem_data;
    logic [31:0] cpu_latch_if_id, cpu_latch_id_ex, cpu_latch_ex_mem, cpu_latch_mem_wb;

    integer      seed = 32'h0a26dc2b;
    string       test_name = "reset";
    logic [31:0] run_cnt, tick = '0, run_len = 32'd10, runs_seen = '0, word, uart_wait;
    logic        uart_busy = 1'b0, cont_mode = 1'b0, step_mode_on = 1'b0, cpu_halt_shown;
    logic [31:0] last_snap [7];
    logic [31:0] snap_exp [7];
    logic [7:0]  dump_bytes [$];
    logic [5:0]  exp_addr [$];
    logic [31:0] exp_data [$];
    int          reset_pulses = 0, erase_pulses = 0;
    logic [5:0]  next_addr = '0;

    always #50 clk = ~clk;

    debug_unit #(.imem_addr_width(6)) u_dut (.*);

    ////////////////////////////////////////////////////////////
    // Failure reporting
    ////////////////////////////////////////////////////////////
    task automatic abort_run(input string why);
        $display("ERROR in %s: %s", test_name, why);
        $display("test failed");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string what, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("CHECK FAILED %s: %s expected %h actual %h", test_name, what, expected, actual);
        $display("test failed");
        $fatal(1);
    endtask

    ////////////////////////////////////////////////////////////
    // Processor model
    ////////////////////////////////////////////////////////////
    always @(posedge clk) begin
        tick <= tick + 1;
        if (reset || cpu_reset) begin
            run_cnt <= '0;
        end else if (cpu_run) begin
            run_cnt <= run_cnt + 1;
        end
        if (cpu_run) begin
            runs_seen <= runs_seen + 1;
        end
        if (cpu_reset) reset_pulses++;
        if (imem_erase) erase_pulses++;
    end

    assign cpu_instr        = (run_cnt >= run_len) ? halt_instr : 32'h2002_0005;
    assign cpu_halt_shown   = cpu_instr[31:26] == debug_pkg::halt_opcode;
    assign cpu_pc           = run_cnt << 2;
    assign cpu_mem_data     = run_cnt ^ 32'h5a5a_0000;
    assign cpu_latch_if_id  = run_cnt + 32'h1000_0000;
    assign cpu_latch_id_ex  = run_cnt + 32'h2000_0000;
    assign cpu_latch_ex_mem = ~run_cnt;
    // Low half keeps moving while a dump is on the wire
    assign cpu_latch_mem_wb = {run_cnt[15:0], tick[15:0]};

    ////////////////////////////////////////////////////////////
    // UART transmit model and snapshot capture
    ////////////////////////////////////////////////////////////
    always @(posedge clk) begin
        tx_done <= 1'b0;
        if (reset) begin
            uart_busy <= 1'b0;
        end else if (tx_start) begin
            assert (!uart_busy && !tx_done)
                else abort_run("tx_start rose before the previous byte finished");
            // Inputs seen one edge earlier are what the dump captured
            if (dump_bytes.size() == 0) snap_exp = last_snap;
            dump_bytes.push_back(tx_data);
            uart_wait <= 1 + $unsigned($random(seed)) % 8;
            uart_busy <= 1'b1;
        end else if (uart_busy) begin
            if (uart_wait == 1) begin
                tx_done   <= 1'b1;
                uart_busy <= 1'b0;
            end else begin
                uart_wait <= uart_wait - 1;
            end
        end
        last_snap = '{cpu_pc, runs_seen, cpu_mem_data, cpu_latch_if_id, cpu_latch_id_ex,
                      cpu_latch_ex_mem, cpu_latch_mem_wb};
    end

    // Instruction memory writes against the words sent
    always @(posedge clk) begin
        if (!reset && imem_we) begin
            if (exp_addr.size() == 0) begin
                abort_run("instruction memory written with no word pending");
            end else begin
                assert (imem_addr == exp_addr[0])
                    else report_mismatch("imem_addr", exp_addr[0], imem_addr);
                assert (imem_wdata == exp_data[0])
                    else report_mismatch("imem_wdata", exp_data[0], imem_wdata);
                void'(exp_addr.pop_front());
                void'(exp_data.pop_front());
            end
        end
    end

    assert property (@(posedge clk) disable iff (reset) cpu_reset |=> !cpu_reset)
        else abort_run("cpu_reset longer than one cycle");
    assert property (@(posedge clk) disable iff (reset) imem_erase |=> !imem_erase)
        else abort_run("imem_erase longer than one cycle");
    assert property (@(posedge clk) disable iff (reset) tx_start |=> !tx_start)
        else abort_run("tx_start longer than one cycle");
    assert property (@(posedge clk) disable iff (reset) cpu_halt_shown |-> !cpu_run)
        else abort_run("cpu_run high while the processor shows a halt");
    assert property (@(posedge clk) disable iff (reset)
                     (cont_mode && $fell(cpu_run)) |-> cpu_halt_shown)
        else abort_run("continuous run stopped before the halt");
    assert property (@(posedge clk) disable iff (reset) (step_mode_on && cpu_run) |=> !cpu_run)
        else abort_run("a step enabled more than one cycle");

    ////////////////////////////////////////////////////////////
    // Stimulus helpers
    ////////////////////////////////////////////////////////////
    task automatic send_byte(input logic [7:0] b);
        repeat ($unsigned($random(seed)) % 4) @(posedge clk);
        @(posedge clk);
        rx_data <= b;
        rx_done <= 1'b1;
        @(posedge clk);
        rx_done <= 1'b0;
    endtask

    task automatic send_word(input logic [31:0] w);
        exp_addr.push_back(next_addr);
        exp_data.push_back(w);
        next_addr++;
        for (int i = 0; i < 4; i++) begin
            send_byte(w[8*i +: 8]);
        end
    endtask

    task automatic wait_writes();
        while (exp_addr.size() != 0) @(posedge clk);
        repeat (4) @(posedge clk);
    endtask

    task automatic check_dump(input logic [31:0] exp_cycles);
        logic [31:0] snap_word;
        // Ends on the tx_done of the last byte
        while (!(tx_done && dump_bytes.size() >= debug_pkg::snapshot_bytes)) @(posedge clk);
        // dump_done and the state change follow the last tx_done
        repeat (3) @(posedge clk);
        assert (dump_bytes.size() == debug_pkg::snapshot_bytes)
            else report_mismatch("dump length", debug_pkg::snapshot_bytes, dump_bytes.size());
        assert (snap_exp[1] == exp_cycles)
            else report_mismatch("cycles seen", exp_cycles, snap_exp[1]);
        for (int i = 0; i < debug_pkg::snapshot_bytes; i++) begin
            snap_word = snap_exp[i / 4];
            assert (dump_bytes[i] == snap_word[8*(i%4) +: 8])
                else report_mismatch($sformatf("dump byte %0d", i), snap_word[8*(i%4) +: 8],
                                     dump_bytes[i]);
        end
        dump_bytes.delete();
    endtask

    ////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////
    initial begin
        repeat (16) @(posedge clk);
        assert (!tx_start && !imem_we && !imem_erase && !cpu_reset && !cpu_run)
            else abort_run("outputs not low after reset");
        reset <= 1'b0;

        test_name = "program load";
        send_byte(debug_pkg::cmd_start);
        for (int i = 0; i < 5; i++) begin
            word = $random(seed);
            word[31:26] = (i == 4) ? debug_pkg::halt_opcode : 6'h08;
            send_word(word);
        end
        wait_writes();

        test_name = "reset and erase";
        send_byte(debug_pkg::cmd_reset_cpu);
        while (reset_pulses == 0) @(posedge clk);
        repeat (4) @(posedge clk);
        assert (reset_pulses == 1) else report_mismatch("cpu_reset pulses", 1, reset_pulses);
        send_byte(debug_pkg::cmd_erase);
        while (erase_pulses == 0) @(posedge clk);
        repeat (4) @(posedge clk);
        assert (erase_pulses == 1) else report_mismatch("imem_erase pulses", 1, erase_pulses);
        next_addr = '0;
        send_byte(debug_pkg::cmd_start);
        send_word({debug_pkg::halt_opcode, 26'h0001234});
        wait_writes();

        test_name = "continuous run";
        cont_mode = 1'b1;
        send_byte(debug_pkg::cmd_continuous);
        check_dump(run_len);
        cont_mode = 1'b0;

        test_name = "step mode";
        send_byte(debug_pkg::cmd_reset_cpu);
        while (reset_pulses == 1) @(posedge clk);
        run_len <= 32'd3;
        runs_seen <= '0;
        step_mode_on = 1'b1;
        send_byte(debug_pkg::cmd_step_mode);
        for (int i = 1; i <= 3; i++) begin
            send_byte(debug_pkg::cmd_step);
            check_dump(i);
        end
        // Halted, so this step is ignored
        send_byte(debug_pkg::cmd_step);
        repeat (8) @(posedge clk);
        assert (runs_seen == 3) else report_mismatch("cycles after halt", 3, runs_seen);
        assert (dump_bytes.size() == 0) else abort_run("dump sent after a step at halt");

        test_name = "continuous after halt";
        step_mode_on = 1'b0;
        runs_seen <= '0;
        send_byte(debug_pkg::cmd_continuous);
        check_dump(0);

        $display("test passed");
        $finish;
    end

    // Watchdog
    initial begin
        repeat (timeout_cycles) @(posedge clk);
        abort_run("watchdog timeout, the DUT stopped responding");
    end

endmodule

`default_nettype wire

// ==== verilog/cycle_counter.sv ====
`default_nettype none

module cycle_counter (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             clear,
    input  logic                             count_en,
    output logic [debug_pkg::word_width-1:0] count
);

    ////////////////////////////////////////////////////////////
    // Enabled processor cycles
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (reset) begin
            count <= '0;
        end else if (clear) begin
            // First run cycle may coincide with the clear
            count <= {{(debug_pkg::word_width-1){1'b0}}, count_en};
        end else if (count_en) begin
            count <= count + 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/debug_fsm.sv ====
`default_nettype none

module debug_fsm (
    input  logic                             clk,
    input  logic                             reset,
    input  logic [debug_pkg::byte_width-1:0] rx_data,
    input  logic                             rx_done,
    input  logic [debug_pkg::word_width-1:0] cpu_instr,
    input  logic                             dump_done,
    output logic                             dump_start,
    output logic                             cycle_clear,
    output logic                             cpu_run,
    output logic                             cpu_reset,
    prog_if.ctrl                             prog
);

    debug_pkg::dbg_state_t state;
    logic                  step_pending;
    logic                  cpu_halt;

    // Current processor instruction is a halt
    assign cpu_halt = cpu_instr[debug_pkg::word_width-1 -: debug_pkg::opcode_width]
                      == debug_pkg::halt_opcode;

    assign prog.load_en = (state == debug_pkg::st_program);

    // One enabled cycle per step, or free running until halt
    assign cpu_run = step_pending || ((state == debug_pkg::st_run) && !cpu_halt);

    ////////////////////////////////////////////////////////////
    // State register and command pulses
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (reset) begin
            state        <= debug_pkg::st_idle;
            step_pending <= 1'b0;
            dump_start   <= 1'b0;
            cycle_clear  <= 1'b0;
            cpu_reset    <= 1'b0;
            prog.erase   <= 1'b0;
        end else begin
            step_pending <= 1'b0;
            dump_start   <= 1'b0;
            cycle_clear  <= 1'b0;
            cpu_reset    <= 1'b0;
            prog.erase   <= 1'b0;

            case (state)
                debug_pkg::st_idle: begin
                    if (rx_done && rx_data == debug_pkg::cmd_start) begin
                        state <= debug_pkg::st_program;
                    end
                end

                debug_pkg::st_program: begin
                    // Last word of the program just went out
                    if (prog.write_en && prog.halt_word) begin
                        state <= debug_pkg::st_wait_cmd;
                    end
                end

                debug_pkg::st_wait_cmd: begin
                    if (rx_done) begin
                        case (rx_data)
                            debug_pkg::cmd_reset_cpu: begin
                                cpu_reset <= 1'b1;
                            end
                            debug_pkg::cmd_erase: begin
                                prog.erase <= 1'b1;
                                state      <= debug_pkg::st_idle;
                            end
                            debug_pkg::cmd_continuous: begin
                                cycle_clear <= 1'b1;
                                state       <= debug_pkg::st_run;
                            end
                            debug_pkg::cmd_step_mode: begin
                                cycle_clear <= 1'b1;
                                state       <= debug_pkg::st_step_mode;
                            end
                            default: begin
                            end
                        endcase
                    end
                end

                debug_pkg::st_step_mode: begin
                    if (step_pending) begin
                        dump_start <= 1'b1;
                        state      <= debug_pkg::st_dump;
                    end else if (rx_done && rx_data == debug_pkg::cmd_step) begin
                        step_pending <= 1'b1;
                    end
                end

                debug_pkg::st_run: begin
                    if (cpu_halt) begin
                        dump_start <= 1'b1;
                        state      <= debug_pkg::st_dump;
                    end
                end

                debug_pkg::st_dump: begin
                    // Serial input is ignored until the snapshot is out
                    if (dump_done) begin
                        state <= cpu_halt ? debug_pkg::st_wait_cmd : debug_pkg::st_step_mode;
                    end
                end

                default: begin
                    state <= debug_pkg::st_idle;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== verilog/debug_pkg.sv ====
`default_nettype none

package debug_pkg;

    ////////////////////////////////////////////////////////////
    // Widths and sizes
    ////////////////////////////////////////////////////////////
    parameter int word_width     = 32;
    parameter int byte_width     = 8;
    parameter int bytes_per_word = 4;
    parameter int snapshot_words = 7;
    parameter int snapshot_bytes = snapshot_words * bytes_per_word;

    // Opcode field sits in bits 31 to 26
    parameter int opcode_width = 6;
    parameter logic [opcode_width-1:0] halt_opcode = 6'b111111;

    ////////////////////////////////////////////////////////////
    // Serial commands
    ////////////////////////////////////////////////////////////
    parameter logic [byte_width-1:0] cmd_start      = 8'd1;
    parameter logic [byte_width-1:0] cmd_continuous = 8'd2;
    parameter logic [byte_width-1:0] cmd_step_mode  = 8'd3;
    parameter logic [byte_width-1:0] cmd_reset_cpu  = 8'd4;
    parameter logic [byte_width-1:0] cmd_erase      = 8'd5;
    parameter logic [byte_width-1:0] cmd_step       = 8'd6;

    // Controller states
    typedef enum logic [2:0] {
        st_idle,
        st_program,
        st_wait_cmd,
        st_step_mode,
        st_run,
        st_dump
    } dbg_state_t;

endpackage

`default_nettype wire

// ==== verilog/debug_unit.sv ====
`default_nettype none

module debug_unit #(
    parameter int imem_addr_width = 6
) (
    input  logic                             clk,
    input  logic                             reset,
    // UART receive and transmit
    input  logic [debug_pkg::byte_width-1:0] rx_data,
    input  logic                             rx_done,
    input  logic                             tx_done,
    output logic                             tx_start,
    output logic [debug_pkg::byte_width-1:0] tx_data,
    // Processor state
    input  logic [debug_pkg::word_width-1:0] cpu_instr,
    input  logic [debug_pkg::word_width-1:0] cpu_pc,
    input  logic [debug_pkg::word_width-1:0] cpu_mem_data,
    input  logic [debug_pkg::word_width-1:0] cpu_latch_if_id,
    input  logic [debug_pkg::word_width-1:0] cpu_latch_id_ex,
    input  logic [debug_pkg::word_width-1:0] cpu_latch_ex_mem,
    input  logic [debug_pkg::word_width-1:0] cpu_latch_mem_wb,
    // Instruction memory
    output logic                             imem_we,
    output logic [imem_addr_width-1:0]       imem_addr,
    output logic [debug_pkg::word_width-1:0] imem_wdata,
    output logic                             imem_erase,
    // Processor control
    output logic                             cpu_reset,
    output logic                             cpu_run
);

    logic                             dump_start;
    logic                             dump_done;
    logic                             cycle_clear;
    logic [debug_pkg::word_width-1:0] cycle_count;

    prog_if #(.imem_addr_width(imem_addr_width)) prog ();

    assign imem_we    = prog.write_en;
    assign imem_addr  = prog.addr;
    assign imem_wdata = prog.word;
    assign imem_erase = prog.erase;

    debug_fsm u_fsm (
        .clk         (clk),
        .reset       (reset),
        .rx_data     (rx_data),
        .rx_done     (rx_done),
        .cpu_instr   (cpu_instr),
        .dump_done   (dump_done),
        .dump_start  (dump_start),
        .cycle_clear (cycle_clear),
        .cpu_run     (cpu_run),
        .cpu_reset   (cpu_reset),
        .prog        (prog.ctrl)
    );

    cycle_counter u_cycles (
        .clk      (clk),
        .reset    (reset),
        .clear    (cycle_clear),
        .count_en (cpu_run),
        .count    (cycle_count)
    );

    instr_loader #(.imem_addr_width(imem_addr_width)) u_loader (
        .clk     (clk),
        .reset   (reset),
        .rx_data (rx_data),
        .rx_done (rx_done),
        .prog    (prog.loader)
    );

    dump_serializer u_dump (
        .clk          (clk),
        .reset        (reset),
        .start        (dump_start),
        .pc           (cpu_pc),
        .cycles       (cycle_count),
        .mem_data     (cpu_mem_data),
        .latch_if_id  (cpu_latch_if_id),
        .latch_id_ex  (cpu_latch_id_ex),
        .latch_ex_mem (cpu_latch_ex_mem),
        .latch_mem_wb (cpu_latch_mem_wb),
        .tx_done      (tx_done),
        .tx_start     (tx_start),
        .tx_data      (tx_data),
        .done         (dump_done)
    );

endmodule

`default_nettype wire

// ==== verilog/dump_serializer.sv ====
`default_nettype none

module dump_serializer (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             start,
    input  logic [debug_pkg::word_width-1:0] pc,
    input  logic [debug_pkg::word_width-1:0] cycles,
    input  logic [debug_pkg::word_width-1:0] mem_data,
    input  logic [debug_pkg::word_width-1:0] latch_if_id,
    input  logic [debug_pkg::word_width-1:0] latch_id_ex,
    input  logic [debug_pkg::word_width-1:0] latch_ex_mem,
    input  logic [debug_pkg::word_width-1:0] latch_mem_wb,
    input  logic                             tx_done,
    output logic                             tx_start,
    output logic [debug_pkg::byte_width-1:0] tx_data,
    output logic                             done
);

    localparam int snap_width = debug_pkg::snapshot_words * debug_pkg::word_width;
    localparam int idx_width  = $clog2(debug_pkg::snapshot_bytes);
    localparam logic [idx_width-1:0] last_idx = idx_width'(debug_pkg::snapshot_bytes - 1);

    logic [snap_width-1:0] snapshot;
    logic [idx_width-1:0]  byte_idx;
    logic                  busy;

    // Byte 0 is the low byte of pc
    assign tx_data = snapshot[byte_idx * debug_pkg::byte_width +: debug_pkg::byte_width];

    ////////////////////////////////////////////////////////////
    // Snapshot capture
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (start && !busy) begin
            snapshot <= {latch_mem_wb, latch_ex_mem, latch_id_ex, latch_if_id,
                         mem_data, cycles, pc};
        end
    end

    ////////////////////////////////////////////////////////////
    // Byte sequencing, one byte per tx_done
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (reset) begin
            busy     <= 1'b0;
            byte_idx <= '0;
            tx_start <= 1'b0;
            done     <= 1'b0;
        end else begin
            tx_start <= 1'b0;
            done     <= 1'b0;

            if (!busy) begin
                if (start) begin
                    busy     <= 1'b1;
                    byte_idx <= '0;
                    tx_start <= 1'b1;
                end
            end else if (tx_done) begin
                if (byte_idx == last_idx) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end else begin
                    byte_idx <= byte_idx + 1'b1;
                    tx_start <= 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/instr_loader.sv ====
`default_nettype none

module instr_loader #(
    parameter int imem_addr_width = 6
) (
    input  logic                             clk,
    input  logic                             reset,
    input  logic [debug_pkg::byte_width-1:0] rx_data,
    input  logic                             rx_done,
    prog_if.loader                           prog
);

    localparam int cnt_width = $clog2(debug_pkg::bytes_per_word);
    localparam logic [cnt_width-1:0] last_byte = cnt_width'(debug_pkg::bytes_per_word - 1);

    logic [cnt_width-1:0] byte_cnt;
    logic                 byte_accept;
    logic                 byte_halt;

    assign byte_accept = prog.load_en && rx_done;

    // Opcode lives in the top bits of the last byte
    assign byte_halt = rx_data[debug_pkg::byte_width-1 -: debug_pkg::opcode_width]
                       == debug_pkg::halt_opcode;

    ////////////////////////////////////////////////////////////
    // Byte position, address and write strobe
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (reset || prog.erase) begin
            byte_cnt       <= '0;
            prog.addr      <= '0;
            prog.write_en  <= 1'b0;
            prog.halt_word <= 1'b0;
        end else begin
            prog.write_en  <= 1'b0;
            prog.halt_word <= 1'b0;

            // Next address once the current word is written
            if (prog.write_en) begin
                prog.addr <= prog.addr + imem_addr_width'(1);
            end

            if (byte_accept) begin
                byte_cnt <= byte_cnt + 1'b1;
                if (byte_cnt == last_byte) begin
                    prog.write_en  <= 1'b1;
                    prog.halt_word <= byte_halt;
                end
            end
        end
    end

    // Word assembly, least significant byte first
    always_ff @(posedge clk) begin
        if (byte_accept) begin
            prog.word[byte_cnt * debug_pkg::byte_width +: debug_pkg::byte_width] <= rx_data;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/prog_if.sv ====
`default_nettype none

interface prog_if #(
    parameter int imem_addr_width = 6
);

    // Controller side
    logic load_en;
    logic erase;

    // Loader side
    logic                              write_en;
    logic [imem_addr_width-1:0]        addr;
    logic [debug_pkg::word_width-1:0]  word;
    logic                              halt_word;

    modport ctrl (
        input  write_en, halt_word,
        output load_en, erase
    );

    modport loader (
        input  load_en, erase,
        output write_en, addr, word, halt_word
    );

endinterface

`default_nettype wire
